// ==== cache_pkg.sv ====
package cache_pkg;

  // control port word addresses
  typedef enum logic [2:0] {
    CTRL_READ_HIT    = 3'd0,
    CTRL_READ_MISS   = 3'd1,
    CTRL_WRITE_HIT   = 3'd2,
    CTRL_WRITE_MISS  = 3'd3,
    CTRL_WTBUF_EMPTY = 3'd4,
    CTRL_INVALIDATE  = 3'd5
  } ctrl_reg_e;

  // owner of the back-end port
  typedef enum logic [1:0] {
    BE_IDLE  = 2'd0,
    BE_WRITE = 2'd1,
    BE_READ  = 2'd2
  } be_state_e;

endpackage

// ==== cache_wtbuf.sv ====
`timescale 1ns/1ps

module cache_wtbuf #(
  parameter int ADDR_W        = 12,
  parameter int DATA_W        = 32,
  parameter int WTBUF_DEPTH_W = 2
) (
  input  logic                clk_i,
  input  logic                reset,
  input  logic                push_i,
  input  logic [ADDR_W-1:0]   push_addr_i,
  input  logic [DATA_W-1:0]   push_wdata_i,
  input  logic [DATA_W/8-1:0] push_wstrb_i,
  input  logic                pop_i,
  output logic [ADDR_W-1:0]   head_addr_o,
  output logic [DATA_W-1:0]   head_wdata_o,
  output logic [DATA_W/8-1:0] head_wstrb_o,
  output logic                empty_o,
  output logic                full_o
);

  localparam int DEPTH = 2 ** WTBUF_DEPTH_W;

  logic [ADDR_W-1:0]      addr_mem  [DEPTH];
  logic [DATA_W-1:0]      wdata_mem [DEPTH];
  logic [DATA_W/8-1:0]    wstrb_mem [DEPTH];
  // extra msb tells full from empty
  logic [WTBUF_DEPTH_W:0] wr_ptr;
  logic [WTBUF_DEPTH_W:0] rd_ptr;

  always_ff @(posedge clk_i or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_i) wr_ptr <= wr_ptr + 1'b1;
      if (pop_i) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_mem[wr_ptr[WTBUF_DEPTH_W-1:0]]  <= push_addr_i;
      wdata_mem[wr_ptr[WTBUF_DEPTH_W-1:0]] <= push_wdata_i;
      wstrb_mem[wr_ptr[WTBUF_DEPTH_W-1:0]] <= push_wstrb_i;
    end
  end

  assign head_addr_o  = addr_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];
  assign head_wdata_o = wdata_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];
  assign head_wstrb_o = wstrb_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];
  assign empty_o      = (wr_ptr == rd_ptr);
  assign full_o       = (wr_ptr[WTBUF_DEPTH_W] != rd_ptr[WTBUF_DEPTH_W]) &&
                        (wr_ptr[WTBUF_DEPTH_W-1:0] == rd_ptr[WTBUF_DEPTH_W-1:0]);

  // the cache holds a write back while full, the back end pops only a queued entry
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset) push_i |-> !full_o)
    else $error("write-through buffer pushed while full");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset) pop_i |-> !empty_o)
    else $error("write-through buffer popped while empty");

endmodule

// ==== cache_memory.sv ====
`timescale 1ns/1ps

module cache_memory #(
  parameter int ADDR_W        = 12,
  parameter int DATA_W        = 32,
  parameter int NLINES_W      = 3,
  parameter int WORD_OFFSET_W = 2,
  parameter int WTBUF_DEPTH_W = 2
) (
  input  logic                clk_i,
  input  logic                reset,
  input  logic                fe_req_i,
  input  logic [ADDR_W-1:0]   fe_addr_i,
  input  logic [DATA_W-1:0]   fe_wdata_i,
  input  logic [DATA_W/8-1:0] fe_wstrb_i,
  output logic [DATA_W-1:0]   fe_rdata_o,
  output logic                fe_ack_o,
  output logic                write_req_o,
  output logic [ADDR_W-1:0]   write_addr_o,
  output logic [DATA_W-1:0]   write_wdata_o,
  output logic [DATA_W/8-1:0] write_wstrb_o,
  input  logic                write_ack_i,
  output logic                read_req_o,
  output logic [ADDR_W-1:0]   read_addr_o,
  input  logic                read_ack_i,
  input  logic [DATA_W-1:0]   read_rdata_i,
  input  logic                invalidate_i,
  output logic                wtbuf_empty_o,
  output logic                write_hit_o,
  output logic                write_miss_o,
  output logic                read_hit_o,
  output logic                read_miss_o
);

  localparam int NLINES = 2 ** NLINES_W;
  localparam int TAG_W  = ADDR_W - NLINES_W - WORD_OFFSET_W;

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_DRAIN,
    MS_REFILL,
    MS_RESP
  } mem_state_e;

  mem_state_e               state;
  logic                     req_pend;
  logic [ADDR_W-1:0]        addr_q;
  logic [DATA_W-1:0]        wdata_q;
  logic [DATA_W/8-1:0]      wstrb_q;
  logic [NLINES-1:0]        valid;
  logic [TAG_W-1:0]         tag_mem  [NLINES];
  logic [DATA_W-1:0]        data_mem [NLINES * 2**WORD_OFFSET_W];
  logic [TAG_W-1:0]         tag;
  logic [NLINES_W-1:0]      index;
  logic [WORD_OFFSET_W-1:0] offset;
  logic [WORD_OFFSET_W-1:0] refill_cnt;
  logic                     hit;
  logic                     is_write;
  logic                     serve;
  logic                     push;
  logic                     wtbuf_full;

  // address split of the registered request
  assign tag    = addr_q[ADDR_W-1 -: TAG_W];
  assign index  = addr_q[WORD_OFFSET_W +: NLINES_W];
  assign offset = addr_q[WORD_OFFSET_W-1:0];

  assign is_write = |wstrb_q;
  assign hit      = valid[index] && (tag_mem[index] == tag);
  // lookup only from idle
  assign serve    = req_pend && (state == MS_IDLE);
  assign push     = serve && is_write && !wtbuf_full;

  assign write_hit_o  = push && hit;
  assign write_miss_o = push && !hit;
  assign read_hit_o   = serve && !is_write && hit;
  assign read_miss_o  = serve && !is_write && !hit;
  assign fe_ack_o     = push || read_hit_o || (state == MS_RESP);
  assign fe_rdata_o   = data_mem[{index, offset}];
  assign read_req_o   = (state == MS_REFILL);
  // refill walks the line from word 0
  assign read_addr_o  = {tag, index, refill_cnt};
  assign write_req_o  = !wtbuf_empty_o;

  always_ff @(posedge clk_i or posedge reset) begin
    if (reset) begin
      req_pend <= 1'b0;
    end else if (fe_req_i) begin
      req_pend <= 1'b1;
    end else if (fe_ack_o) begin
      req_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fe_req_i) begin
      addr_q  <= fe_addr_i;
      wdata_q <= fe_wdata_i;
      wstrb_q <= fe_wstrb_i;
    end
  end

  always_ff @(posedge clk_i or posedge reset) begin
    if (reset) begin
      state      <= MS_IDLE;
      refill_cnt <= '0;
    end else begin
      case (state)
        MS_IDLE: if (read_miss_o) state <= MS_DRAIN;
        // memory must hold every buffered write before the line is fetched
        MS_DRAIN: if (wtbuf_empty_o) state <= MS_REFILL;
        MS_REFILL: begin
          if (read_ack_i) begin
            refill_cnt <= refill_cnt + 1'b1;
            if (&refill_cnt) state <= MS_RESP;
          end
        end
        default: state <= MS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge reset) begin
    if (reset) begin
      valid <= '0;
    end else if (invalidate_i) begin
      valid <= '0;
    end else if (read_req_o && read_ack_i && (&refill_cnt)) begin
      valid[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_req_o && read_ack_i) begin
      data_mem[{index, refill_cnt}] <= read_rdata_i;
      if (&refill_cnt) tag_mem[index] <= tag;
    end else if (write_hit_o) begin
      // merge only the strobed bytes
      for (int b = 0; b < DATA_W/8; b++) begin
        if (wstrb_q[b]) data_mem[{index, offset}][8*b +: 8] <= wdata_q[8*b +: 8];
      end
    end
  end

  cache_wtbuf #(
    .ADDR_W       (ADDR_W),
    .DATA_W       (DATA_W),
    .WTBUF_DEPTH_W(WTBUF_DEPTH_W)
  ) wtbuf_inst (
    .clk_i       (clk_i),
    .reset       (reset),
    .push_i      (push),
    .push_addr_i (addr_q),
    .push_wdata_i(wdata_q),
    .push_wstrb_i(wstrb_q),
    .pop_i       (write_ack_i),
    .head_addr_o (write_addr_o),
    .head_wdata_o(write_wdata_o),
    .head_wstrb_o(write_wstrb_o),
    .empty_o     (wtbuf_empty_o),
    .full_o      (wtbuf_full)
  );

  // requester waits for each ack before the next request
  a_ack_single: assert property (@(posedge clk_i) disable iff (reset) fe_ack_o |=> !fe_ack_o)
    else $error("front-end ack held for two cycles");

endmodule

// ==== cache_back_end.sv ====
`timescale 1ns/1ps

module cache_back_end
  import cache_pkg::*;
#(
  parameter int ADDR_W = 12,
  parameter int DATA_W = 32
) (
  input  logic                clk_i,
  input  logic                reset,
  input  logic                write_req_i,
  input  logic [ADDR_W-1:0]   write_addr_i,
  input  logic [DATA_W-1:0]   write_wdata_i,
  input  logic [DATA_W/8-1:0] write_wstrb_i,
  output logic                write_ack_o,
  input  logic                read_req_i,
  input  logic [ADDR_W-1:0]   read_addr_i,
  output logic                read_ack_o,
  output logic [DATA_W-1:0]   read_rdata_o,
  output logic                be_req_o,
  output logic [ADDR_W-1:0]   be_addr_o,
  output logic [DATA_W-1:0]   be_wdata_o,
  output logic [DATA_W/8-1:0] be_wstrb_o,
  input  logic [DATA_W-1:0]   be_rdata_i,
  input  logic                be_ack_i
);

  be_state_e state;

  always_ff @(posedge clk_i or posedge reset) begin
    if (reset) begin
      state <= BE_IDLE;
    end else begin
      case (state)
        // buffered writes go first
        BE_IDLE: begin
          if (write_req_i) state <= BE_WRITE;
          else if (read_req_i) state <= BE_READ;
        end
        default: begin
          if (be_ack_i) state <= BE_IDLE;
        end
      endcase
    end
  end

  // latch the transfer so the port holds still until the ack
  always_ff @(posedge clk_i) begin
    if (state == BE_IDLE) begin
      if (write_req_i) begin
        be_addr_o  <= write_addr_i;
        be_wdata_o <= write_wdata_i;
        be_wstrb_o <= write_wstrb_i;
      end else begin
        be_addr_o  <= read_addr_i;
        be_wdata_o <= '0;
        be_wstrb_o <= '0;
      end
    end
  end

  // idle state after every ack gives the required low cycle
  assign be_req_o     = (state != BE_IDLE);
  assign write_ack_o  = (state == BE_WRITE) && be_ack_i;
  assign read_ack_o   = (state == BE_READ) && be_ack_i;
  assign read_rdata_o = be_rdata_i;

  a_addr_stable: assert property (@(posedge clk_i) disable iff (reset)
    be_req_o && !be_ack_i |=> $stable(be_addr_o))
    else $error("back-end address moved under a pending request");

endmodule

// ==== cache_control.sv ====
`timescale 1ns/1ps

module cache_control
  import cache_pkg::*;
#(
  parameter int DATA_W = 32,
  parameter int CNT_W  = 16
) (
  input  logic              clk_i,
  input  logic              reset,
  input  logic              ctrl_req_i,
  input  ctrl_reg_e         ctrl_addr_i,
  input  logic              ctrl_wr_i,
  output logic [DATA_W-1:0] ctrl_rdata_o,
  output logic              ctrl_ack_o,
  input  logic              write_hit_i,
  input  logic              write_miss_i,
  input  logic              read_hit_i,
  input  logic              read_miss_i,
  input  logic              wtbuf_empty_i,
  output logic              invalidate_o
);

  // counters in register map order
  logic [CNT_W-1:0] cnt [4];
  logic [3:0]       events;

  assign events = {write_miss_i, write_hit_i, read_miss_i, read_hit_i};

  always_ff @(posedge clk_i or posedge reset) begin
    if (reset) begin
      ctrl_ack_o   <= 1'b0;
      invalidate_o <= 1'b0;
      for (int i = 0; i < 4; i++) cnt[i] <= '0;
    end else begin
      ctrl_ack_o   <= ctrl_req_i;
      invalidate_o <= ctrl_req_i && ctrl_wr_i && (ctrl_addr_i == CTRL_INVALIDATE);
      // saturate at all ones
      for (int i = 0; i < 4; i++) begin
        if (invalidate_o) cnt[i] <= '0;
        else if (events[i] && !(&cnt[i])) cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_req_i) begin
      case (ctrl_addr_i)
        CTRL_READ_HIT, CTRL_READ_MISS, CTRL_WRITE_HIT, CTRL_WRITE_MISS:
          ctrl_rdata_o <= DATA_W'(cnt[ctrl_addr_i[1:0]]);
        CTRL_WTBUF_EMPTY: ctrl_rdata_o <= DATA_W'(wtbuf_empty_i);
        default: ctrl_rdata_o <= '0;
      endcase
    end
  end

endmodule

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
#(
  parameter int ADDR_W        = 12,
  parameter int DATA_W        = 32,
  parameter int NLINES_W      = 3,
  parameter int WORD_OFFSET_W = 2,
  parameter int WTBUF_DEPTH_W = 2,
  parameter int CNT_W         = 16
) (
  input  logic                clk_i,
  input  logic                reset,
  input  logic                fe_req_i,
  input  logic [ADDR_W-1:0]   fe_addr_i,
  input  logic [DATA_W-1:0]   fe_wdata_i,
  input  logic [DATA_W/8-1:0] fe_wstrb_i,
  output logic [DATA_W-1:0]   fe_rdata_o,
  output logic                fe_ack_o,
  input  logic                ctrl_req_i,
  input  ctrl_reg_e           ctrl_addr_i,
  input  logic                ctrl_wr_i,
  output logic [DATA_W-1:0]   ctrl_rdata_o,
  output logic                ctrl_ack_o,
  output logic                be_req_o,
  output logic [ADDR_W-1:0]   be_addr_o,
  output logic [DATA_W-1:0]   be_wdata_o,
  output logic [DATA_W/8-1:0] be_wstrb_o,
  input  logic [DATA_W-1:0]   be_rdata_i,
  input  logic                be_ack_i
);

  // write-drain channel
  logic                write_req;
  logic [ADDR_W-1:0]   write_addr;
  logic [DATA_W-1:0]   write_wdata;
  logic [DATA_W/8-1:0] write_wstrb;
  logic                write_ack;
  // refill channel
  logic                read_req;
  logic [ADDR_W-1:0]   read_addr;
  logic                read_ack;
  logic [DATA_W-1:0]   read_rdata;
  // events and invalidate
  logic                wtbuf_empty;
  logic                write_hit;
  logic                write_miss;
  logic                read_hit;
  logic                read_miss;
  logic                invalidate;

  cache_memory #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .NLINES_W(NLINES_W),
    .WORD_OFFSET_W(WORD_OFFSET_W), .WTBUF_DEPTH_W(WTBUF_DEPTH_W)
  ) memory_inst (
    .clk_i(clk_i), .reset(reset),
    .fe_req_i(fe_req_i), .fe_addr_i(fe_addr_i), .fe_wdata_i(fe_wdata_i),
    .fe_wstrb_i(fe_wstrb_i), .fe_rdata_o(fe_rdata_o), .fe_ack_o(fe_ack_o),
    .write_req_o(write_req), .write_addr_o(write_addr), .write_wdata_o(write_wdata),
    .write_wstrb_o(write_wstrb), .write_ack_i(write_ack),
    .read_req_o(read_req), .read_addr_o(read_addr),
    .read_ack_i(read_ack), .read_rdata_i(read_rdata),
    .invalidate_i(invalidate), .wtbuf_empty_o(wtbuf_empty),
    .write_hit_o(write_hit), .write_miss_o(write_miss),
    .read_hit_o(read_hit), .read_miss_o(read_miss)
  );

  cache_back_end #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W)
  ) back_end_inst (
    .clk_i(clk_i), .reset(reset),
    .write_req_i(write_req), .write_addr_i(write_addr), .write_wdata_i(write_wdata),
    .write_wstrb_i(write_wstrb), .write_ack_o(write_ack),
    .read_req_i(read_req), .read_addr_i(read_addr),
    .read_ack_o(read_ack), .read_rdata_o(read_rdata),
    .be_req_o(be_req_o), .be_addr_o(be_addr_o), .be_wdata_o(be_wdata_o),
    .be_wstrb_o(be_wstrb_o), .be_rdata_i(be_rdata_i), .be_ack_i(be_ack_i)
  );

  cache_control #(
    .DATA_W(DATA_W), .CNT_W(CNT_W)
  ) control_inst (
    .clk_i(clk_i), .reset(reset),
    .ctrl_req_i(ctrl_req_i), .ctrl_addr_i(ctrl_addr_i), .ctrl_wr_i(ctrl_wr_i),
    .ctrl_rdata_o(ctrl_rdata_o), .ctrl_ack_o(ctrl_ack_o),
    .write_hit_i(write_hit), .write_miss_i(write_miss),
    .read_hit_i(read_hit), .read_miss_i(read_miss),
    .wtbuf_empty_i(wtbuf_empty), .invalidate_o(invalidate)
  );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

endmodule

// ==== cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*;
();

  localparam int ADDR_W     = 12;
  localparam int DATA_W     = 32;
  localparam int NUM_RANDOM = 300;
  // about four times the worst-case length of all tests
  localparam int MAX_CYCLES = 20000;

  logic              clk_i;
  logic              reset;
  logic              fe_req_i;
  logic [ADDR_W-1:0] fe_addr_i;
  logic [DATA_W-1:0] fe_wdata_i;
  logic [3:0]        fe_wstrb_i;
  logic [DATA_W-1:0] fe_rdata_o;
  logic              fe_ack_o;
  logic              ctrl_req_i;
  ctrl_reg_e         ctrl_addr_i;
  logic              ctrl_wr_i;
  logic [DATA_W-1:0] ctrl_rdata_o;
  logic              ctrl_ack_o;
  logic              be_req_o;
  logic [ADDR_W-1:0] be_addr_o;
  logic [DATA_W-1:0] be_wdata_o;
  logic [3:0]        be_wstrb_o;
  logic [DATA_W-1:0] be_rdata_i;
  logic              be_ack_i;

  logic [DATA_W-1:0] mem_model [int];
  logic [DATA_W-1:0] shadow_mem [int];
  logic [6:0]        shadow_tag [8];
  logic [7:0]        shadow_valid;
  // {addr, data, strobe} in the order the back end must see them
  logic [47:0]       write_q [$];
  // {is_read, hit, data} per front-end access
  logic [33:0]       expect_q [$];
  logic [33:0]       mon_entry;
  logic [47:0]       wr_entry;
  logic              mon_active;
  logic              mem_busy;
  int                mon_cycles;
  int                mem_wait;
  int                extra_delay;
  int                errors;
  int                reads_checked;
  int                writes_checked;
  int                cycle_cnt;
  int                exp_cnt [4];
  int                seed = 32'hbc2d3f35;
  logic [ADDR_W-1:0] rnd_addr [NUM_RANDOM];
  logic [DATA_W-1:0] rnd_data [NUM_RANDOM];
  logic [3:0]        rnd_strb [NUM_RANDOM];

  tb_clock #(.PERIOD_NS(8.0)) clock_inst (.clk_o(clk_i));

  cache_top #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .NLINES_W(3),
    .WORD_OFFSET_W(2), .WTBUF_DEPTH_W(2), .CNT_W(16)
  ) cache_top_inst (.*);

  // every address gets its own pattern before any write
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return {4'ha, addr, 4'h5, ~addr};
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] new_word, input logic [3:0] strb);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    if (mem_model.exists(int'(addr))) return mem_model[int'(addr)];
    return fill_word(addr);
  endfunction

  // write-through keeps the expected word equal to the last merged write
  function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
    if (shadow_mem.exists(int'(addr))) return shadow_mem[int'(addr)];
    return fill_word(addr);
  endfunction

  // direct mapped with the index in bits 4:2 and the tag in bits 11:5
  function automatic logic predict_hit(input logic [ADDR_W-1:0] addr);
    return shadow_valid[addr[4:2]] && (shadow_tag[addr[4:2]] == addr[11:5]);
  endfunction

  task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
      input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic fe_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
      input logic [3:0] strb, output int lat);
    fe_req_i   = 1'b1;
    fe_addr_i  = addr;
    fe_wdata_i = wdata;
    fe_wstrb_i = strb;
    lat = 0;
    do begin
      @(posedge clk_i);
      #1;
      fe_req_i = 1'b0;
      lat++;
    end while (!fe_ack_o);
    @(posedge clk_i);
    #1;
  endtask

  task automatic read_op(input logic [ADDR_W-1:0] addr);
    logic hit;
    int   lat;
    hit = predict_hit(addr);
    expect_q.push_back({1'b1, hit, ref_read(addr)});
    if (hit) begin
      exp_cnt[0]++;
    end else begin
      // a read miss allocates the line
      exp_cnt[1]++;
      shadow_valid[addr[4:2]] = 1'b1;
      shadow_tag[addr[4:2]]   = addr[11:5];
    end
    fe_access(addr, '0, 4'h0, lat);
  endtask

  task automatic write_op(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
      input logic [3:0] strb, output int lat);
    if (predict_hit(addr)) exp_cnt[2]++;
    else exp_cnt[3]++;
    shadow_mem[int'(addr)] = merge_bytes(ref_read(addr), data, strb);
    write_q.push_back({addr, data, strb});
    expect_q.push_back({1'b0, 1'b0, 32'h0});
    fe_access(addr, data, strb, lat);
  endtask

  task automatic ctrl_access(input ctrl_reg_e addr, input logic wr,
      output logic [DATA_W-1:0] rdata);
    ctrl_req_i  = 1'b1;
    ctrl_addr_i = addr;
    ctrl_wr_i   = wr;
    @(posedge clk_i);
    #1;
    ctrl_req_i = 1'b0;
    ctrl_wr_i  = 1'b0;
    check_eq(32'(ctrl_ack_o), 32'd1, "control ack one cycle after request");
    rdata = ctrl_rdata_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_counters();
    logic [DATA_W-1:0] value;
    for (int i = 0; i < 4; i++) begin
      ctrl_access(ctrl_reg_e'(i), 1'b0, value);
      check_eq(value, 32'(exp_cnt[i]), $sformatf("event counter %0d", i));
    end
  endtask

  task automatic wait_drain();
    while (write_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
  endtask

  // back-end memory with a random wait of 0 to 3 cycles plus the slow-down
  initial begin
    be_ack_i   = 1'b0;
    be_rdata_i = '0;
    mem_busy   = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      be_ack_i = 1'b0;
      if (reset || !be_req_o) begin
        mem_busy = 1'b0;
      end else begin
        if (!mem_busy) begin
          mem_busy = 1'b1;
          mem_wait = ($random(seed) & 3) + extra_delay;
        end
        if (mem_wait != 0) begin
          mem_wait--;
        end else begin
          mem_busy = 1'b0;
          be_ack_i = 1'b1;
          be_rdata_i = mem_word(be_addr_o);
          if (|be_wstrb_o && write_q.size() == 0) begin
            errors++;
            $display("back-end write at %0t ns with no front-end write pending", $time);
          end else if (|be_wstrb_o) begin
            wr_entry = write_q.pop_front();
            writes_checked++;
            check_eq(32'(be_addr_o), 32'(wr_entry[47:36]), "back-end write address");
            check_eq(be_wdata_o, wr_entry[35:4], "back-end write data");
            check_eq(32'(be_wstrb_o), 32'(wr_entry[3:0]), "back-end write strobe");
            mem_model[int'(be_addr_o)] = merge_bytes(mem_word(be_addr_o), be_wdata_o,
                                                     be_wstrb_o);
          end
        end
      end
    end
  end

  // sampled mid-cycle after outputs settle
  always @(negedge clk_i) begin
    if (reset) begin
      mon_active = 1'b0;
    end else if (fe_req_i) begin
      mon_active = 1'b1;
      mon_cycles = 0;
    end else if (fe_ack_o && !mon_active) begin
      errors++;
      $display("front-end ack at %0t ns without a request", $time);
    end else if (mon_active) begin
      mon_cycles++;
      if (fe_ack_o) begin
        mon_active = 1'b0;
        mon_entry  = expect_q.pop_front();
        if (mon_entry[33]) begin
          reads_checked++;
          check_eq(fe_rdata_o, mon_entry[31:0], $sformatf("read data at %h", fe_addr_i));
          // only a hit answers in the next cycle
          check_eq(32'(mon_cycles == 1), 32'(mon_entry[32]),
                   $sformatf("hit timing at %h", fe_addr_i));
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    logic [DATA_W-1:0] value;
    logic [31:0]       r;
    int                lat;
    int                stalls;
    reset        = 1'b1;
    fe_req_i     = 1'b0;
    fe_addr_i    = '0;
    fe_wdata_i   = '0;
    fe_wstrb_i   = '0;
    ctrl_req_i   = 1'b0;
    ctrl_addr_i  = CTRL_READ_HIT;
    ctrl_wr_i    = 1'b0;
    extra_delay  = 0;
    errors       = 0;
    shadow_valid = '0;
    foreach (exp_cnt[i]) exp_cnt[i] = 0;
    // about 40 percent writes over 128 words so lines conflict often
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      rnd_addr[i] = 12'(r[6:0]);
      rnd_data[i] = $random(seed);
      if (r[10:8] < 3'd3) rnd_strb[i] = (r[14:11] == 4'h0) ? 4'hf : r[14:11];
      else rnd_strb[i] = 4'h0;
    end
    repeat (3) @(posedge clk_i);
    #1;
    reset = 1'b0;
    @(posedge clk_i);
    #1;

    // cold miss then hits across the line
    read_op(12'h040);
    read_op(12'h040);
    for (int w = 1; w < 4; w++) read_op(12'h040 + 12'(w));

    // byte writes that hit and miss before a conflicting line evicts one
    write_op(12'h041, 32'hdead_beef, 4'b0011, lat);
    write_op(12'h100, 32'h1234_5678, 4'b1100, lat);
    read_op(12'h041);
    read_op(12'h061);
    read_op(12'h041);
    read_op(12'h100);

    // more writes than buffer entries into a slow memory
    extra_delay = 8;
    stalls = 0;
    for (int i = 0; i < 8; i++) begin
      write_op(12'h200 + 12'(i), 32'hc0de_0000 + i, 4'hf, lat);
      if (lat > 1) stalls++;
    end
    check_eq(32'(stalls > 0), 32'd1, "front end stalled on a full buffer");
    ctrl_access(CTRL_WTBUF_EMPTY, 1'b0, value);
    check_eq(value, 32'd0, "buffer empty flag with writes queued");
    wait_drain();
    ctrl_access(CTRL_WTBUF_EMPTY, 1'b0, value);
    check_eq(value, 32'd1, "buffer empty flag after drain");
    extra_delay = 0;
    for (int i = 0; i < 8; i++) read_op(12'h200 + 12'(i));

    check_counters();

    // invalidate clears lines and counters
    ctrl_access(CTRL_INVALIDATE, 1'b1, value);
    foreach (exp_cnt[i]) exp_cnt[i] = 0;
    shadow_valid = '0;
    check_counters();
    read_op(12'h040);
    check_counters();

    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (rnd_strb[i] == 4'h0) read_op(rnd_addr[i]);
      else write_op(rnd_addr[i], rnd_data[i], rnd_strb[i], lat);
    end
    check_counters();
    wait_drain();
    check_eq(32'(expect_q.size()), 32'd0, "front-end accesses left unanswered");

    $display("errors: %0d, reads checked: %0d, back-end writes checked: %0d",
             errors, reads_checked, writes_checked);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
cache_pkg.sv
cache_wtbuf.sv
cache_memory.sv
cache_back_end.sv
cache_control.sv
cache_top.sv
tb_clock.sv
cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f src.f \
  -o cache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/cache_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$log_file"; then
  exit 1
fi
exit 0
